//--- rtl/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // word select within a block
    localparam int OFFSET_W        = 2;
    localparam int WORDS_PER_BLOCK = 4;

    // processor side data word
    typedef logic [31:0] word_t;

    // processor addresses words, not bytes
    typedef logic [29:0] proc_addr_t;

    // memory side address, word address without the offset
    typedef logic [$bits(proc_addr_t)-OFFSET_W-1:0] block_addr_t;

endpackage

`default_nettype wire

//--- rtl/cache_line_pkg.sv
`default_nettype none

package cache_line_pkg;

    import cache_geom_pkg::*;

    // one memory block, 128 bits
    typedef logic [WORDS_PER_BLOCK*$bits(word_t)-1:0] block_t;

    // word k sits at bits 32k+31:32k
    typedef union packed
    {
        block_t                           flat;
        word_t [WORDS_PER_BLOCK-1:0]      words;
    } line_data_u;

    // miss handling states
    typedef enum logic [1:0]
    {
        st_idle       = 2'd0,
        st_write_back = 2'd1,
        st_refill     = 2'd2,
        st_merge      = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/tag_lookup.sv
`default_nettype none

module tag_lookup
    import cache_geom_pkg::*;
#(
    parameter int INDEX_W = 3
) (
    input  logic                                    clk,
    input  logic                                    proc_reset,
    input  logic [INDEX_W-1:0]                      index,
    input  logic [$bits(block_addr_t)-INDEX_W-1:0]  req_tag,
    input  logic                                    fill,
    input  logic                                    set_dirty,
    input  logic                                    clear_dirty,
    output logic                                    hit,
    output logic                                    victim_dirty,
    output logic [$bits(block_addr_t)-INDEX_W-1:0]  victim_tag
);

    localparam int TAG_W = $bits(block_addr_t) - INDEX_W;
    localparam int LINES = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem [LINES];
    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;

    logic [TAG_W-1:0] cur_tag;

    assign cur_tag = tag_mem[index];

    assign hit          = valid_q[index] && (cur_tag == req_tag);
    assign victim_dirty = valid_q[index] && dirty_q[index];
    assign victim_tag   = cur_tag;

    // tag array
    always_ff @(posedge clk)
    begin
        if (fill)
            tag_mem[index] <= req_tag;
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (fill)
        begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;   // fresh block is clean
        end
        else if (set_dirty)
            dirty_q[index] <= 1'b1;
        else if (clear_dirty)
            dirty_q[index] <= 1'b0;   // victim written back
    end

endmodule

`default_nettype wire

//--- rtl/line_store.sv
`default_nettype none

module line_store
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
#(
    parameter int INDEX_W = 3
) (
    input  logic                 clk,
    input  logic                 proc_reset,
    input  logic [INDEX_W-1:0]   index,
    input  logic [OFFSET_W-1:0]  offset,
    input  logic                 fill_en,
    input  block_t               fill_data,
    input  logic                 write_en,
    input  word_t                wdata,
    output word_t                rdata,
    output line_data_u           line_data
);

    localparam int LINES = 1 << INDEX_W;

    line_data_u store [LINES];

    line_data_u cur_line;
    line_data_u next_line;

    assign cur_line = store[index];

    // read side
    assign rdata     = cur_line.words[offset];
    assign line_data = cur_line;   // whole block for write-back

    // refill replaces the block, a write merges one word
    always_comb
    begin
        next_line = cur_line;
        if (fill_en)
            next_line.flat = fill_data;
        else
            next_line.words[offset] = wdata;
    end

    // data array
    always_ff @(posedge clk)
    begin
        if (!proc_reset && (fill_en || write_en))
            store[index] <= next_line;
    end

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
`default_nettype none

module cache_ctrl
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
#(
    parameter int INDEX_W = 3
) (
    input  logic                                    clk,
    input  logic                                    proc_reset,
    input  logic                                    proc_read,
    input  logic                                    proc_write,
    input  proc_addr_t                              proc_addr,
    input  logic                                    hit,
    input  logic                                    victim_dirty,
    input  logic [$bits(block_addr_t)-INDEX_W-1:0]  victim_tag,
    input  logic                                    mem_done,
    output logic                                    proc_stall,
    output logic                                    fill,
    output logic                                    set_dirty,
    output logic                                    clear_dirty,
    output logic                                    fill_en,
    output logic                                    write_en,
    output logic                                    start_read,
    output logic                                    start_write,
    output block_addr_t                             req_block_addr
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic               req;
    logic               miss;
    logic [INDEX_W-1:0] index;
    block_addr_t        req_addr;
    block_addr_t        victim_addr;

    assign req  = proc_read || proc_write;
    assign miss = req && !hit;

    assign index       = proc_addr[OFFSET_W +: INDEX_W];
    assign req_addr    = proc_addr[$bits(proc_addr_t)-1:OFFSET_W];
    assign victim_addr = {victim_tag, index};

    // processor waits until idle and hitting
    assign proc_stall = req && ((state_q != st_idle) || !hit);

    // victim address only when evicting
    assign req_block_addr = start_write ? victim_addr : req_addr;

    always_comb
    begin
        state_d     = state_q;
        fill        = 1'b0;
        fill_en     = 1'b0;
        write_en    = 1'b0;
        set_dirty   = 1'b0;
        clear_dirty = 1'b0;
        start_read  = 1'b0;
        start_write = 1'b0;

        case (state_q)
            st_idle:
            begin
                if (miss && victim_dirty)
                begin
                    start_write = 1'b1;
                    state_d     = st_write_back;
                end
                else if (miss)
                begin
                    start_read = 1'b1;
                    state_d    = st_refill;
                end
                else if (proc_write)
                begin
                    write_en  = 1'b1;   // write hit, never goes to memory
                    set_dirty = 1'b1;
                end
            end
            st_write_back:
            begin
                if (mem_done)
                begin
                    clear_dirty = 1'b1;
                    start_read  = 1'b1;  // refill right after write-back
                    state_d     = st_refill;
                end
            end
            st_refill:
            begin
                if (mem_done)
                begin
                    fill    = 1'b1;
                    fill_en = 1'b1;
                    state_d = proc_write ? st_merge : st_idle;
                end
            end
            st_merge:
            begin
                write_en  = 1'b1;
                set_dirty = 1'b1;
                state_d   = st_idle;
            end
            default:
                state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
            state_q <= st_idle;
        else
            state_q <= state_d;
    end

endmodule

`default_nettype wire

//--- rtl/mem_port.sv
`default_nettype none

module mem_port
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
(
    input  logic         clk,
    input  logic         proc_reset,
    input  logic         start_read,
    input  logic         start_write,
    input  block_addr_t  req_block_addr,
    input  line_data_u   line_data,
    input  logic         mem_ready,
    output logic         mem_done,
    output logic         mem_read,
    output logic         mem_write,
    output block_addr_t  mem_addr,
    output block_t       mem_wdata
);

    logic pending;

    assign pending  = mem_read || mem_write;
    assign mem_done = pending && mem_ready;   // ready only counts for our request

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            mem_addr  <= '0;
            mem_wdata <= '0;
        end
        else if (start_read || start_write)
        begin
            mem_read  <= start_read;
            mem_write <= start_write;
            mem_addr  <= req_block_addr;
            if (start_write)
                mem_wdata <= line_data.flat;   // victim block
        end
        else if (mem_done)
        begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
`default_nettype none

module cache_top
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
#(
    parameter int INDEX_W = 3
) (
    input  logic         clk,
    input  logic         proc_reset,
    input  logic         proc_read,
    input  logic         proc_write,
    input  proc_addr_t   proc_addr,
    input  word_t        proc_wdata,
    output logic         proc_stall,
    output word_t        proc_rdata,
    output logic         mem_read,
    output logic         mem_write,
    output block_addr_t  mem_addr,
    input  block_t       mem_rdata,
    output block_t       mem_wdata,
    input  logic         mem_ready
);

    localparam int TAG_W = $bits(block_addr_t) - INDEX_W;

    // address split
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;

    logic                hit;
    logic                victim_dirty;
    logic [TAG_W-1:0]    victim_tag;
    logic                fill;
    logic                set_dirty;
    logic                clear_dirty;
    logic                fill_en;
    logic                write_en;
    logic                start_read;
    logic                start_write;
    block_addr_t         req_block_addr;
    line_data_u          line_data;
    logic                mem_done;

    assign offset = proc_addr[OFFSET_W-1:0];
    assign index  = proc_addr[OFFSET_W +: INDEX_W];
    assign tag    = proc_addr[$bits(proc_addr_t)-1 -: TAG_W];

    tag_lookup #(
        .INDEX_W (INDEX_W)
    ) u_tag_lookup (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (index),
        .req_tag      (tag),
        .fill         (fill),
        .set_dirty    (set_dirty),
        .clear_dirty  (clear_dirty),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    line_store #(
        .INDEX_W (INDEX_W)
    ) u_line_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (index),
        .offset     (offset),
        .fill_en    (fill_en),
        .fill_data  (mem_rdata),
        .write_en   (write_en),
        .wdata      (proc_wdata),
        .rdata      (proc_rdata),
        .line_data  (line_data)
    );

    cache_ctrl #(
        .INDEX_W (INDEX_W)
    ) u_cache_ctrl (
        .clk            (clk),
        .proc_reset     (proc_reset),
        .proc_read      (proc_read),
        .proc_write     (proc_write),
        .proc_addr      (proc_addr),
        .hit            (hit),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag),
        .mem_done       (mem_done),
        .proc_stall     (proc_stall),
        .fill           (fill),
        .set_dirty      (set_dirty),
        .clear_dirty    (clear_dirty),
        .fill_en        (fill_en),
        .write_en       (write_en),
        .start_read     (start_read),
        .start_write    (start_write),
        .req_block_addr (req_block_addr)
    );

    mem_port u_mem_port (
        .clk            (clk),
        .proc_reset     (proc_reset),
        .start_read     (start_read),
        .start_write    (start_write),
        .req_block_addr (req_block_addr),
        .line_data      (line_data),
        .mem_ready      (mem_ready),
        .mem_done       (mem_done),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

endmodule

`default_nettype wire

//--- testbench/tb_mem_model.sv
`default_nettype none

module tb_mem_model
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
#(
    parameter word_t FILL_XOR = 32'h0
) (
    input  logic         clk,
    input  logic         proc_reset,
    input  logic         mem_read,
    input  logic         mem_write,
    input  block_addr_t  mem_addr,
    input  block_t       mem_wdata,
    output block_t       mem_rdata,
    output logic         mem_ready,
    output int           read_count,
    output int           write_count,
    output block_addr_t  last_wr_addr,
    output block_t       last_wr_data
);

    block_t      blocks [block_addr_t];
    logic        busy;
    int unsigned wait_cnt;
    int unsigned lcg_state;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // blocks never written read back the address pattern
    function automatic block_t read_block(input block_addr_t a);
        block_t b;
        if (blocks.exists(a))
            return blocks[a];
        for (int k = 0; k < WORDS_PER_BLOCK; k++)
            b[32*k +: 32] = {2'b00, a, 2'(k)} ^ FILL_XOR;
        return b;
    endfunction

    always @(posedge clk)
    begin
        if (proc_reset)
        begin
            mem_ready    <= 1'b0;
            mem_rdata    <= '0;
            busy         <= 1'b0;
            wait_cnt     <= 0;
            read_count   <= 0;
            write_count  <= 0;
            lcg_state    <= 99;
            last_wr_addr <= '0;
            last_wr_data <= '0;
        end
        else if (mem_ready)
            mem_ready <= 1'b0;   // request taken at this edge
        else if (busy)
        begin
            if (wait_cnt <= 1)
            begin
                busy      <= 1'b0;
                mem_ready <= 1'b1;
                if (mem_write)
                begin
                    blocks[mem_addr] = mem_wdata;
                    write_count  <= write_count + 1;
                    last_wr_addr <= mem_addr;
                    last_wr_data <= mem_wdata;
                end
                else
                begin
                    mem_rdata  <= read_block(mem_addr);
                    read_count <= read_count + 1;
                end
            end
            else
                wait_cnt <= wait_cnt - 1;
        end
        else if (mem_read || mem_write)
        begin
            busy      <= 1'b1;
            lcg_state <= lcg_next(lcg_state);
            wait_cnt  <= 1 + (lcg_next(lcg_state) >> 16) % 4;   // 1 to 4 cycles
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_cache_assert.sv
`default_nettype none

module tb_cache_assert
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
(
    input  logic         clk,
    input  logic         proc_reset,
    input  logic         mem_read,
    input  logic         mem_write,
    input  logic         mem_ready,
    input  logic         mem_done,
    input  block_addr_t  mem_addr,
    input  block_t       mem_wdata
);

    int fail_count = 0;

    no_dual_request: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
    else
    begin
        fail_count++;
        $error("memory read and write requested together");
    end

    // request held until the memory answers
    request_stable: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |=> $stable(mem_addr) && $stable(mem_wdata))
    else
    begin
        fail_count++;
        $error("memory address or write data changed while a request was pending");
    end

    // every memory answer completes a pending request
    ready_answers_request: assert property (@(posedge clk) disable iff (proc_reset)
        mem_ready |-> mem_done)
    else
    begin
        fail_count++;
        $error("mem_ready seen without a pending request");
    end

endmodule

bind mem_port tb_cache_assert port_checks (
    .clk        (clk),
    .proc_reset (proc_reset),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_ready  (mem_ready),
    .mem_done   (mem_done),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
);

`default_nettype wire

//--- testbench/tb_cache.sv
`default_nettype none

module tb_cache
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
();

    localparam int    INDEX_W       = 3;
    localparam int    TAG_W         = $bits(block_addr_t) - INDEX_W;
    localparam int    LINES         = 1 << INDEX_W;
    localparam int    MAX_ENTRIES   = 64;
    localparam int    N_RANDOM      = 40;
    localparam int    STALL_TIMEOUT = 50;
    localparam word_t FILL_XOR      = 32'h5EED_C0DE;

    logic        clk;
    logic        proc_reset;
    logic        proc_read;
    logic        proc_write;
    proc_addr_t  proc_addr;
    word_t       proc_wdata;
    logic        proc_stall;
    word_t       proc_rdata;
    logic        mem_read;
    logic        mem_write;
    block_addr_t mem_addr;
    block_t      mem_rdata;
    block_t      mem_wdata;
    logic        mem_ready;
    int          mem_reads;
    int          mem_writes;
    block_addr_t last_wr_addr;
    block_t      last_wr_data;

    // stimulus table with expected results
    logic        op_tab      [MAX_ENTRIES];   // 1 = write
    proc_addr_t  addr_tab    [MAX_ENTRIES];
    word_t       wdata_tab   [MAX_ENTRIES];
    logic        hit_tab     [MAX_ENTRIES];
    word_t       rdata_tab   [MAX_ENTRIES];
    int          reads_tab   [MAX_ENTRIES];
    int          writes_tab  [MAX_ENTRIES];
    block_addr_t wb_addr_tab [MAX_ENTRIES];
    block_t      wb_data_tab [MAX_ENTRIES];
    int          n_entries = 0;

    // reference model
    word_t            ref_mem   [proc_addr_t];
    logic             ref_valid [LINES];
    logic             ref_dirty [LINES];
    logic [TAG_W-1:0] ref_tag   [LINES];
    int unsigned      lcg_state = 99;
    int               base_reads;
    int               base_writes;

    cache_top #(
        .INDEX_W (INDEX_W)
    ) uut (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready)
    );

    tb_mem_model #(
        .FILL_XOR (FILL_XOR)
    ) memory (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .read_count   (mem_reads),
        .write_count  (mem_writes),
        .last_wr_addr (last_wr_addr),
        .last_wr_data (last_wr_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t init_word(input proc_addr_t a);
        return {2'b00, a} ^ FILL_XOR;
    endfunction

    function automatic word_t ref_read(input proc_addr_t a);
        if (ref_mem.exists(a))
            return ref_mem[a];
        return init_word(a);
    endfunction

    function automatic proc_addr_t make_addr(input int tag, input int idx, input int off);
        return {TAG_W'(tag), INDEX_W'(idx), OFFSET_W'(off)};
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp)
            fail_run($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // predicts hit, memory traffic and read data from the line state
    function automatic void add_entry(input logic is_write, input proc_addr_t a, input word_t d);
        block_addr_t        blk;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        int                 n;
        blk = a[$bits(proc_addr_t)-1:OFFSET_W];
        idx = blk[INDEX_W-1:0];
        tag = blk[$bits(block_addr_t)-1:INDEX_W];
        n   = n_entries;
        op_tab[n]      = is_write;
        addr_tab[n]    = a;
        wdata_tab[n]   = d;
        hit_tab[n]     = ref_valid[idx] && (ref_tag[idx] == tag);
        reads_tab[n]   = 0;
        writes_tab[n]  = 0;
        wb_addr_tab[n] = '0;
        wb_data_tab[n] = '0;
        if (!hit_tab[n])
        begin
            if (ref_valid[idx] && ref_dirty[idx])
            begin
                writes_tab[n]  = 1;   // victim goes back first
                wb_addr_tab[n] = {ref_tag[idx], idx};
                for (int k = 0; k < WORDS_PER_BLOCK; k++)
                    wb_data_tab[n][32*k +: 32] = ref_read({wb_addr_tab[n], OFFSET_W'(k)});
            end
            reads_tab[n]   = 1;
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
            ref_dirty[idx] = 1'b0;
        end
        if (is_write)
        begin
            ref_mem[a]     = d;
            ref_dirty[idx] = 1'b1;
        end
        rdata_tab[n] = ref_read(a);
        n_entries    = n + 1;
    endfunction

    task automatic build_table();
        int unsigned r;
        for (int i = 0; i < LINES; i++)
        begin
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        add_entry(1'b0, make_addr(1, 2, 1), '0);            // cold read miss
        add_entry(1'b0, make_addr(1, 2, 3), '0);            // same block, hit
        add_entry(1'b1, make_addr(2, 5, 0), 32'hCAFE_0001); // write miss
        add_entry(1'b0, make_addr(2, 5, 0), '0);
        add_entry(1'b0, make_addr(3, 5, 2), '0);            // dirty eviction
        add_entry(1'b0, make_addr(2, 5, 0), '0);
        add_entry(1'b1, make_addr(2, 5, 1), 32'h0BAD_F00D); // write hit
        add_entry(1'b0, make_addr(2, 5, 1), '0);
        for (int i = 0; i < N_RANDOM; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            r         = lcg_state >> 16;
            lcg_state = lcg_next(lcg_state);
            // few tags per index so lines get evicted
            add_entry(r[15], make_addr((r >> 8) % 3, (r >> 4) % LINES, r % 4), lcg_state);
        end
    endtask

    task automatic apply_entry(input int n);
        int waited;
        @(posedge clk);
        proc_read  <= !op_tab[n];
        proc_write <= op_tab[n];
        proc_addr  <= addr_tab[n];
        proc_wdata <= wdata_tab[n];
        @(negedge clk);
        compare("proc_stall", proc_stall, !hit_tab[n]);
        waited = 0;
        while (proc_stall)
        begin
            if (waited == STALL_TIMEOUT)
                fail_run($sformatf("timeout: proc_stall stayed high on table entry %0d", n));
            waited++;
            @(negedge clk);
        end
        if (!op_tab[n])
            compare("proc_rdata", proc_rdata, rdata_tab[n]);
        compare("mem_read count", mem_reads - base_reads, reads_tab[n]);
        compare("mem_write count", mem_writes - base_writes, writes_tab[n]);
        if (writes_tab[n] == 1)
        begin
            compare("mem_addr", last_wr_addr, wb_addr_tab[n]);
            compare("mem_wdata", last_wr_data, wb_data_tab[n]);
        end
        base_reads  = mem_reads;
        base_writes = mem_writes;
    endtask

    initial
    begin
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        build_table();
        repeat (3) @(posedge clk);
        proc_reset <= 1'b0;
        @(negedge clk);
        base_reads  = mem_reads;
        base_writes = mem_writes;
        for (int n = 0; n < n_entries; n++)
            apply_entry(n);
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        @(negedge clk);
        if (uut.u_mem_port.port_checks.fail_count != 0)
            fail_run("memory port assertions failed during the run");
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- compile.f
rtl/cache_geom_pkg.sv
rtl/cache_line_pkg.sv
rtl/tag_lookup.sv
rtl/line_store.sv
rtl/cache_ctrl.sv
rtl/mem_port.sv
rtl/cache_top.sv
testbench/tb_mem_model.sv
testbench/tb_cache_assert.sv
testbench/tb_cache.sv
